// File: project.f
hdl/memPkg.sv
hdl/loadAlign.sv
hdl/memRequest.sv
hdl/dataRam.sv
hdl/memoryStage.sv
hdl/writebackStage.sv
hdl/memPipeTop.sv
dv/memPipeTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= memPipeTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: dv/memPipeTb.sv
`timescale 1ns/1ps

module memPipeTb;
    import memPkg::*;

    // must match the default in memPipeTop
    localparam int UNCACHED_DELAY = 4;
    // cycles a single wait may spin
    localparam int WAIT_LIMIT = 200;

    logic            clk;
    logic            resetn;
    execSlot_t [1:0] exec;
    logic            execValid;
    logic            execReady;
    wbSlot_t [1:0]   commit;

    // shadow copy of the data RAM, word indexed like the DUT
    logic [31:0] shadow [256];
    wbSlot_t     expQ [$];
    wbSlot_t     gotQ [$];
    logic [31:0] pcNext;
    integer      seed;
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          errAtStart;
    string       curTest;
    logic        timedOut = 1'b0;
    string       timeoutWhat;

    memPipeTop u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .exec      (exec),
        .execValid (execValid),
        .execReady (execReady),
        .commit    (commit)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // commits sampled mid cycle, older lane first
    always @(negedge clk) begin
        if (resetn) begin
            if (commit[1].valid) gotQ.push_back(commit[1]);
            if (commit[0].valid) gotQ.push_back(commit[0]);
        end
    end

    // ends the run when a wait gives up
    initial begin
        wait (timedOut);
        $display("timeout waiting for %s", timeoutWhat);
        $display("** FAIL **");
        $finish;
    end

    // reference extension: shift the lane down, then mask or extend
    function automatic logic [31:0] alignRef(logic [31:0] word, logic [1:0] off,
                                             msize_t size, logic sext);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (size)
            MSIZE_B: return (sext && sh[7]) ? (sh | 32'hffff_ff00) : (sh & 32'h0000_00ff);
            MSIZE_H: return (sext && sh[15]) ? (sh | 32'hffff_0000) : (sh & 32'h0000_ffff);
            default: return word;
        endcase
    endfunction

    function automatic execSlot_t makeLoad(logic [31:0] addr, msize_t size, logic sext,
                                           logic [4:0] rdst);
        execSlot_t s;
        s = '0;
        s.valid       = 1'b1;
        s.rdst        = rdst;
        s.aluOut      = addr;
        s.ctl.memRead = 1'b1;
        s.ctl.msize   = size;
        s.ctl.memSext = sext;
        s.ctl.regWrite = 1'b1;
        return s;
    endfunction

    function automatic execSlot_t makeStore(logic [31:0] addr, logic [31:0] data, msize_t size);
        execSlot_t s;
        s = '0;
        s.valid        = 1'b1;
        s.aluOut       = addr;
        s.srcb         = data;
        s.ctl.memWrite = 1'b1;
        s.ctl.msize    = size;
        return s;
    endfunction

    function automatic execSlot_t makeAlu(logic [31:0] value, logic [4:0] rdst, logic wr);
        execSlot_t s;
        s = '0;
        s.valid        = 1'b1;
        s.rdst         = rdst;
        s.aluOut       = value;
        s.ctl.msize    = MSIZE_W;
        s.ctl.regWrite = wr;
        return s;
    endfunction

    // any op, any size, naturally aligned inside the first 16 words
    function automatic execSlot_t randomSlot();
        logic [31:0] r;
        logic [31:0] addr;
        msize_t      size;
        r = $random(seed);
        case (r[1:0])
            2'd0:    size = MSIZE_B;
            2'd1:    size = MSIZE_H;
            default: size = MSIZE_W;
        endcase
        addr = '0;
        // about one in four goes uncached
        addr[29]  = r[4] & r[5];
        addr[5:2] = r[9:6];
        case (size)
            MSIZE_B: addr[1:0] = r[11:10];
            MSIZE_H: addr[1:0] = {r[10], 1'b0};
            default: addr[1:0] = 2'b00;
        endcase
        case (r[13:12])
            2'b00, 2'b01: return makeLoad(addr, size, r[14], r[19:15]);
            2'b10:        return makeStore(addr, $random(seed), size);
            default:      return makeAlu($random(seed), r[19:15], r[14]);
        endcase
    endfunction

    task automatic stallOnTimeout(string what);
        timeoutWhat = what;
        timedOut    = 1'b1;
        forever @(posedge clk);
    endtask

    // reads see the old contents, then lane 1 writes, then lane 0
    task automatic predictPair(execSlot_t s1, execSlot_t s0);
        execSlot_t [1:0] s;
        logic [31:0]     rd [2];
        wbSlot_t         e;
        int              nBytes;
        int              pos;
        s = {s1, s0};
        for (int i = 1; i >= 0; i--) rd[i] = shadow[s[i].aluOut[9:2]];
        for (int i = 1; i >= 0; i--) begin
            if (s[i].valid && s[i].ctl.memWrite) begin
                nBytes = (s[i].ctl.msize == MSIZE_B) ? 1 : (s[i].ctl.msize == MSIZE_H) ? 2 : 4;
                for (int b = 0; b < nBytes; b++) begin
                    pos = int'(s[i].aluOut[1:0]) + b;
                    shadow[s[i].aluOut[9:2]][pos*8 +: 8] = s[i].srcb[b*8 +: 8];
                end
            end
        end
        for (int i = 1; i >= 0; i--) begin
            if (s[i].valid) begin
                e.valid    = 1'b1;
                e.pc       = s[i].pc;
                e.rdst     = s[i].rdst;
                e.wdata    = s[i].ctl.memRead ?
                             alignRef(rd[i], s[i].aluOut[1:0], s[i].ctl.msize, s[i].ctl.memSext) :
                             s[i].aluOut;
                e.regWrite = s[i].ctl.regWrite && (s[i].rdst != 5'd0);
                expQ.push_back(e);
            end
        end
    endtask

    task automatic checkWb(string what, wbSlot_t got, wbSlot_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got pc=%h rdst=%h wdata=%h regWrite=%h valid=%h",
                     what, got.pc, got.rdst, got.wdata, got.regWrite, got.valid);
            $display("    expected pc=%h rdst=%h wdata=%h regWrite=%h valid=%h",
                     exp.pc, exp.rdst, exp.wdata, exp.regWrite, exp.valid);
        end
    endtask

    task automatic checkReady(string what, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch execReady (%s): got %h expected %h", what, got, exp);
        end
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (!execReady && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!execReady) stallOnTimeout("execReady");
    endtask

    // entered and left 1 ns after a rising edge
    task automatic sendPair(execSlot_t s1, execSlot_t s0);
        waitReady();
        s1.pc  = pcNext;
        s0.pc  = pcNext + 32'd4;
        pcNext = pcNext + 32'd8;
        predictPair(s1, s0);
        exec[1]   = s1;
        exec[0]   = s0;
        execValid = 1'b1;
        @(posedge clk);
        #1;
        execValid = 1'b0;
        exec      = '0;
    endtask

    // drains every predicted commit and compares in issue order
    task automatic waitCommit();
        int waited;
        waited = 0;
        while (gotQ.size() < expQ.size() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (gotQ.size() < expQ.size()) begin
            stallOnTimeout("commit");
        end else begin
            while (expQ.size() > 0) checkWb("commit", gotQ.pop_front(), expQ.pop_front());
            if (gotQ.size() != 0) begin
                errors++;
                $display("%0d commits arrived that no pair accounts for", gotQ.size());
                gotQ.delete();
            end
        end
    endtask

    // pair just sent, held off for the whole slow access
    task automatic expectSlowPair(string what);
        for (int c = 0; c < UNCACHED_DELAY; c++) begin
            checkReady({what, " busy"}, execReady, 1'b0);
            if (gotQ.size() != 0) begin
                errors++;
                $display("commit arrived before the uncached access finished");
            end
            @(posedge clk);
            #1;
        end
        checkReady({what, " done"}, execReady, 1'b1);
    endtask

    task automatic startTest(string name);
        curTest    = name;
        errAtStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors == errAtStart) begin
            $display("%-26s ok", curTest);
        end else begin
            testsFailed++;
            $display("%-26s failed, %0d errors", curTest, errors - errAtStart);
        end
    endtask

    task automatic testResetState();
        startTest("reset state");
        checkReady("after reset", execReady, 1'b1);
        if (commit[1].valid || commit[0].valid) begin
            errors++;
            $display("commit valid is high right after reset");
        end
        endTest();
    endtask

    // also fills words 0..15 so later loads never read unknown data
    task automatic testWordStoreLoad();
        execSlot_t s1;
        execSlot_t s0;
        startTest("word store and load");
        for (int i = 0; i < 16; i += 2) begin
            sendPair(makeStore(32'(i * 4), 32'h8a5c_31f7 ^ (32'(i) * 32'h0107_1933), MSIZE_W),
                     makeStore(32'(i * 4 + 4), 32'h7e02_c9b4 + (32'(i) * 32'h2468_0ace), MSIZE_W));
        end
        for (int i = 0; i < 16; i += 2) begin
            s1 = makeLoad(32'(i * 4), MSIZE_W, 1'b0, 5'(i + 1));
            s0 = makeLoad(32'(i * 4 + 4), MSIZE_W, 1'b1, 5'(i + 2));
            // some loads without a register write
            s0.ctl.regWrite = i[1];
            sendPair(s1, s0);
        end
        waitCommit();
        endTest();
    endtask

    task automatic testSubWordLoads();
        startTest("byte and half loads");
        // bytes and halves with the top bit both set and clear
        sendPair(makeStore(32'h14, 32'h7f80_61e3, MSIZE_W),
                 makeStore(32'h18, 32'h80e3_f17f, MSIZE_W));
        for (int sx = 0; sx < 2; sx++) begin
            for (int off = 0; off < 4; off++) begin
                sendPair(makeLoad(32'h14 + 32'(off), MSIZE_B, sx[0], 5'd3),
                         makeLoad(32'h18 + 32'(off), MSIZE_B, sx[0], 5'd4));
            end
            for (int off = 0; off < 4; off += 2) begin
                sendPair(makeLoad(32'h14 + 32'(off), MSIZE_H, sx[0], 5'd3),
                         makeLoad(32'h18 + 32'(off), MSIZE_H, sx[0], 5'd4));
            end
        end
        waitCommit();
        endTest();
    endtask

    task automatic testSubWordStores();
        startTest("sub-word stores");
        // byte 1 of word 8 written by both lanes, lane 0 wins
        sendPair(makeStore(32'h21, 32'h0000_00a5, MSIZE_B),
                 makeStore(32'h20, 32'h0000_3c96, MSIZE_H));
        sendPair(makeStore(32'h27, 32'h0000_0011, MSIZE_B),
                 makeStore(32'h24, 32'h0000_00e2, MSIZE_B));
        sendPair(makeStore(32'h2a, 32'hffff_d00d, MSIZE_H),
                 makeStore(32'h2e, 32'h0000_005a, MSIZE_B));
        sendPair(makeLoad(32'h20, MSIZE_W, 1'b0, 5'd5), makeLoad(32'h24, MSIZE_W, 1'b0, 5'd6));
        sendPair(makeLoad(32'h28, MSIZE_W, 1'b0, 5'd7), makeLoad(32'h2c, MSIZE_W, 1'b0, 5'd8));
        waitCommit();
        endTest();
    endtask

    task automatic testUncached();
        startTest("uncached access");
        sendPair(makeStore(32'h2000_0030, 32'hc4a1_0f3e, MSIZE_W),
                 makeLoad(32'h2000_0034, MSIZE_W, 1'b0, 5'd9));
        expectSlowPair("both lanes uncached");
        waitCommit();
        // one slow lane is enough to slow the pair
        sendPair(makeLoad(32'h2000_0030, MSIZE_W, 1'b0, 5'd10),
                 makeLoad(32'h0000_0034, MSIZE_H, 1'b1, 5'd11));
        expectSlowPair("lane 1 uncached");
        waitCommit();
        endTest();
    endtask

    task automatic testNonMemory();
        startTest("non-memory pair");
        sendPair(makeAlu(32'h1234_5678, 5'd12, 1'b1), makeAlu(32'hfeed_0042, 5'd0, 1'b1));
        // done at once, no bus wait
        checkReady("non-memory pair", execReady, 1'b1);
        waitCommit();
        endTest();
    endtask

    task automatic testRandomStream();
        startTest("random back-to-back");
        for (int n = 0; n < 40; n++) sendPair(randomSlot(), randomSlot());
        waitCommit();
        endTest();
    endtask

    initial begin
        seed        = 32'h35f3_7ae3;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        pcNext      = 32'h0000_1000;
        resetn      = 1'b0;
        execValid   = 1'b0;
        exec        = '0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        testResetState();
        testWordStoreLoad();
        testSubWordLoads();
        testSubWordStores();
        testUncached();
        testNonMemory();
        testRandomStream();

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: hdl/memPipeTop.sv
`timescale 1ns/1ps

module memPipeTop #(
    parameter int RAM_WORDS      = 256,
    parameter int UNCACHED_DELAY = 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  memPkg::execSlot_t [1:0]  exec,
    input  logic                     execValid,
    output logic                     execReady,
    output memPkg::wbSlot_t [1:0]    commit
);
    import memPkg::*;

    execSlot_t [1:0] reqSlot;
    dbusReq_t [1:0]  dreq;
    dbusResp_t       dresp;
    logic            dWait;
    // memory results, same cycle as dataOk
    memSlot_t [1:0]  memOut;
    logic            pairDone;

    memRequest u_memRequest (
        .clk       (clk),
        .resetn    (resetn),
        .exec      (exec),
        .execValid (execValid),
        .execReady (execReady),
        .reqSlot   (reqSlot),
        .dreq      (dreq),
        .dresp     (dresp),
        .dWait     (dWait),
        .pairDone  (pairDone)
    );

    dataRam #(
        .RAM_WORDS      (RAM_WORDS),
        .UNCACHED_DELAY (UNCACHED_DELAY)
    ) u_dataRam (
        .clk    (clk),
        .resetn (resetn),
        .dreq   (dreq),
        .dresp  (dresp),
        .dWait  (dWait)
    );

    memoryStage u_memoryStage (
        .reqSlot (reqSlot),
        .dresp   (dresp),
        .memOut  (memOut)
    );

    writebackStage u_writebackStage (
        .clk      (clk),
        .resetn   (resetn),
        .memOut   (memOut),
        .pairDone (pairDone),
        .commit   (commit)
    );

endmodule

// File: hdl/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input  logic                    clk,
    input  logic                    resetn,
    input  memPkg::memSlot_t [1:0]  memOut,
    input  logic                    pairDone,
    output memPkg::wbSlot_t [1:0]   commit
);
    logic [1:0]       commitValid;
    logic [1:0][31:0] pcQ;
    logic [1:0][4:0]  rdstQ;
    logic [1:0][31:0] wdataQ;
    logic [1:0]       regWriteQ;

    // valid is a single cycle per finished pair
    always_ff @(posedge clk) begin
        if (!resetn) begin
            commitValid <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                commitValid[i] <= pairDone & memOut[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pairDone) begin
            for (int i = 0; i < 2; i++) begin
                pcQ[i]       <= memOut[i].pc;
                rdstQ[i]     <= memOut[i].rdst;
                // load value, else the ALU result
                wdataQ[i]    <= memOut[i].ctl.memRead ? memOut[i].ld : memOut[i].aluOut;
                // r0 never written
                regWriteQ[i] <= memOut[i].ctl.regWrite & (memOut[i].rdst != 5'd0);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit[i].valid    = commitValid[i];
            commit[i].pc       = pcQ[i];
            commit[i].rdst     = rdstQ[i];
            commit[i].wdata    = wdataQ[i];
            commit[i].regWrite = regWriteQ[i];
        end
    end

endmodule

// File: hdl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  memPkg::execSlot_t [1:0] reqSlot,
    input  memPkg::dbusResp_t       dresp,
    output memPkg::memSlot_t [1:0]  memOut
);
    logic [1:0][31:0] laneData;
    logic [1:0][1:0]  laneOffset;
    logic [1:0][31:0] laneLoad;

    // lane 1 reads data1, lane 0 reads data0
    assign laneData = {dresp.data1, dresp.data0};

    for (genvar i = 0; i < 2; i++) begin : g_lane
        // non-loads align at offset zero, keeps the aligner quiet
        assign laneOffset[i] = (reqSlot[i].valid && reqSlot[i].ctl.memRead) ?
                               reqSlot[i].aluOut[1:0] : 2'b00;

        loadAlign u_align (
            .rawWord (laneData[i]),
            .offset  (laneOffset[i]),
            .msize   (reqSlot[i].ctl.msize),
            .memSext (reqSlot[i].ctl.memSext),
            .loaded  (laneLoad[i])
        );
    end

    // slot fields pass straight through
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            memOut[i].valid  = reqSlot[i].valid;
            memOut[i].pc     = reqSlot[i].pc;
            memOut[i].rdst   = reqSlot[i].rdst;
            memOut[i].aluOut = reqSlot[i].aluOut;
            memOut[i].ld     = laneLoad[i];
            memOut[i].ctl    = reqSlot[i].ctl;
        end
    end

endmodule

// File: hdl/dataRam.sv
`timescale 1ns/1ps

module dataRam #(
    parameter int RAM_WORDS      = 256,
    parameter int UNCACHED_DELAY = 4
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  memPkg::dbusReq_t [1:0]  dreq,
    output memPkg::dbusResp_t       dresp,
    output logic                    dWait
);
    // word index width
    localparam int AW = $clog2(RAM_WORDS);
    // countdown width
    localparam int CW = $clog2(UNCACHED_DELAY + 1);

    logic [31:0]   mem [RAM_WORDS];
    logic [31:0]   rdata1;
    logic [31:0]   rdata0;
    logic          busy;
    logic [CW-1:0] count;
    logic          dataOk;
    logic          anyValid;
    logic          uncached;
    logic          slowPath;
    logic          accept;

    assign anyValid = dreq[1].valid | dreq[0].valid;
    // bit 29 on either live lane selects the slow region
    assign uncached = (dreq[1].valid & dreq[1].addr[29]) |
                      (dreq[0].valid & dreq[0].addr[29]);
    assign slowPath = uncached & (UNCACHED_DELAY > 1);
    // request still shows in the dataOk cycle, so skip it there
    assign accept   = anyValid & ~busy & ~dataOk;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy   <= 1'b0;
            count  <= '0;
            dataOk <= 1'b0;
        end else begin
            // one cycle pulse
            dataOk <= 1'b0;
            if (accept) begin
                if (slowPath) begin
                    busy  <= 1'b1;
                    count <= CW'(UNCACHED_DELAY - 1);
                end else begin
                    dataOk <= 1'b1;
                end
            end else if (busy) begin
                if (count == CW'(1)) begin
                    busy   <= 1'b0;
                    dataOk <= 1'b1;
                end
                count <= count - 1'b1;
            end
        end
    end

    // all access happens on the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            // reads see contents from before this pair
            rdata1 <= mem[dreq[1].addr[AW+1:2]];
            rdata0 <= mem[dreq[0].addr[AW+1:2]];
            // lane 1 first, lane 0 last so the younger store wins
            for (int l = 1; l >= 0; l--) begin
                for (int b = 0; b < 4; b++) begin
                    if (dreq[l].valid && dreq[l].strobe[b]) begin
                        mem[dreq[l].addr[AW+1:2]][b*8 +: 8] <= dreq[l].wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        dresp.dataOk = dataOk;
        dresp.data1  = rdata1;
        dresp.data0  = rdata0;
    end

    assign dWait = anyValid & ~dataOk;

    // a response always pairs with a live request from memRequest
    assert property (@(posedge clk) disable iff (!resetn)
        dresp.dataOk |-> anyValid)
        else $error("dataRam: dataOk without a valid request");

endmodule

// File: hdl/memRequest.sv
`timescale 1ns/1ps

module memRequest (
    input  logic                      clk,
    input  logic                      resetn,
    input  memPkg::execSlot_t [1:0]   exec,
    input  logic                      execValid,
    output logic                      execReady,
    output memPkg::execSlot_t [1:0]   reqSlot,
    output memPkg::dbusReq_t [1:0]    dreq,
    input  memPkg::dbusResp_t         dresp,
    input  logic                      dWait,
    output logic                      pairDone
);
    import memPkg::*;

    // held pair, payload only
    execSlot_t [1:0] pairQ;
    logic            slotFull;
    logic [1:0]      memOp;
    logic            accept;

    always_comb begin
        reqSlot = pairQ;
        // lane valid only counts while a pair is held
        reqSlot[1].valid = slotFull & pairQ[1].valid;
        reqSlot[0].valid = slotFull & pairQ[0].valid;
        for (int i = 0; i < 2; i++) begin
            memOp[i] = reqSlot[i].valid &
                       (reqSlot[i].ctl.memRead | reqSlot[i].ctl.memWrite);
        end
    end

    // no memory op means done at once
    assign pairDone  = slotFull & (dresp.dataOk | (memOp == 2'b00));
    assign execReady = ~slotFull | pairDone;
    assign accept    = execValid & execReady;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slotFull <= 1'b0;
        end else if (accept) begin
            slotFull <= 1'b1;
        end else if (pairDone) begin
            slotFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pairQ <= exec;
        end
    end

    // per lane request, stays up through the dataOk cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dreq[i].valid = memOp[i];
            dreq[i].addr  = reqSlot[i].aluOut;
            dreq[i].size  = reqSlot[i].ctl.msize;
            case (reqSlot[i].ctl.msize)
                MSIZE_B: begin
                    dreq[i].strobe = 4'b0001 << reqSlot[i].aluOut[1:0];
                    // byte copied into every lane
                    dreq[i].wdata  = {4{reqSlot[i].srcb[7:0]}};
                end
                MSIZE_H: begin
                    dreq[i].strobe = reqSlot[i].aluOut[1] ? 4'b1100 : 4'b0011;
                    dreq[i].wdata  = {2{reqSlot[i].srcb[15:0]}};
                end
                default: begin
                    dreq[i].strobe = 4'b1111;
                    dreq[i].wdata  = reqSlot[i].srcb;
                end
            endcase
            // loads must not touch memory
            if (!reqSlot[i].ctl.memWrite) begin
                dreq[i].strobe = 4'b0000;
            end
        end
    end

    // RAM still working on this pair, so it must stay put
    assert property (@(posedge clk) disable iff (!resetn)
        dWait |=> $stable(reqSlot))
        else $error("memRequest: reqSlot changed while the bus was waiting");

endmodule

// File: hdl/loadAlign.sv
`timescale 1ns/1ps

module loadAlign (
    input  logic [31:0]    rawWord,
    input  logic [1:0]     offset,
    input  memPkg::msize_t msize,
    input  logic           memSext,
    output logic [31:0]    loaded
);
    import memPkg::*;

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    always_comb begin
        // byte lane picked by the low address bits
        byteSel = rawWord[{offset, 3'b000} +: 8];
        // upper or lower half
        halfSel = offset[1] ? rawWord[31:16] : rawWord[15:0];
        case (msize)
            MSIZE_B: loaded = {{24{memSext & byteSel[7]}}, byteSel};
            MSIZE_H: loaded = {{16{memSext & halfSel[15]}}, halfSel};
            // word, passes unchanged
            default: loaded = rawWord;
        endcase
    end

    // issuing side guarantees natural alignment
    always_comb begin
        if (msize == MSIZE_H) begin
            assert (offset[0] == 1'b0)
                else $error("loadAlign: misaligned half offset %0d", offset);
        end
        if (msize == MSIZE_W) begin
            assert (offset == 2'b00)
                else $error("loadAlign: misaligned word offset %0d", offset);
        end
    end

endmodule

// File: hdl/memPkg.sv
package memPkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        MSIZE_B = 2'd0,
        MSIZE_H = 2'd1,
        MSIZE_W = 2'd2
    } msize_t;

    // memory side control carried with each slot
    typedef struct packed {
        logic   memRead;
        logic   memWrite;
        msize_t msize;
        // sign extend on load
        logic   memSext;
        logic   regWrite;
    } memCtl_t;

    // one execute slot, lane 1 older, lane 0 younger
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rdst;
        // effective address for memory ops
        logic [31:0] aluOut;
        // store data, unshifted
        logic [31:0] srcb;
        memCtl_t     ctl;
    } execSlot_t;

    // per lane data bus request
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        msize_t      size;
        logic [3:0]  strobe;
        logic [31:0] wdata;
    } dbusReq_t;

    // single response shared by both lanes
    typedef struct packed {
        logic        dataOk;
        logic [31:0] data1;
        logic [31:0] data0;
    } dbusResp_t;

    // slot leaving the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rdst;
        logic [31:0] aluOut;
        // aligned and extended load value
        logic [31:0] ld;
        memCtl_t     ctl;
    } memSlot_t;

    // committed result per lane
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rdst;
        logic [31:0] wdata;
        logic        regWrite;
    } wbSlot_t;

endpackage
